//--- rtl/slicer_pkg.sv
`default_nettype none

package slicer_pkg;

    //////////////////////////////
    // widths

    localparam int unsigned NUM_LANES = 8;
    localparam int unsigned COORD_W = 12;
    localparam int unsigned Z_W = 14;
    // ids wrap
    localparam int unsigned ID_W = 8;
    localparam int unsigned SCORE_W = 16;
    localparam int unsigned HEALTH_W = 4;
    localparam int unsigned COMBO_W = 3;

    // one bit per lane, used for busy / valid / grant vectors
    typedef logic [NUM_LANES-1:0] lane_vec_t;

    //////////////////////////////
    // game constants

    // spawn depth, 16 ticks to reach the player
    localparam logic [Z_W-1:0] SPAWN_Z = 14'd1600;
    localparam logic [Z_W-1:0] BLOCK_SPEED = 14'd100;
    localparam logic [Z_W-1:0] HIT_ZONE_Z = 14'd400;
    // per axis hit window
    localparam logic [COORD_W-1:0] HIT_RADIUS = 12'd64;
    localparam logic [COORD_W-1:0] MIN_SWING = 12'd16;
    localparam logic [HEALTH_W-1:0] MAX_HEALTH = 4'd4;
    localparam logic [SCORE_W-1:0] SLICE_POINTS = 16'd10;
    localparam logic [COMBO_W-1:0] MAX_COMBO = 3'd4;

    //////////////////////////////
    // enums

    // DIR_ANY only appears on blocks
    typedef enum logic [2:0] {
        DIR_NONE, DIR_UP, DIR_DOWN, DIR_LEFT, DIR_RIGHT, DIR_ANY
    } swing_dir_t;

    typedef enum logic {COLOR_LEFT = 1'b0, COLOR_RIGHT = 1'b1} block_color_t;

    typedef enum logic [1:0] {ST_IDLE, ST_PLAYING, ST_OVER} play_state_t;

    typedef enum logic {EV_MISS, EV_SLICE} lane_event_t;

endpackage

`default_nettype wire

//--- rtl/slicer_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// saber positions plus swing per hand
interface saber_if;
    logic [slicer_pkg::COORD_W-1:0] left_x;
    logic [slicer_pkg::COORD_W-1:0] left_y;
    slicer_pkg::swing_dir_t left_dir;
    logic [slicer_pkg::COORD_W-1:0] right_x;
    logic [slicer_pkg::COORD_W-1:0] right_y;
    slicer_pkg::swing_dir_t right_dir;

    modport tracker(output left_x, left_y, left_dir, right_x, right_y, right_dir);
    modport lane(input left_x, left_y, left_dir, right_x, right_y, right_dir);
endinterface

// scheduler to lane, load is a single cycle pulse
interface lane_load_if;
    logic load;
    logic [slicer_pkg::COORD_W-1:0] x;
    logic [slicer_pkg::COORD_W-1:0] y;
    slicer_pkg::block_color_t color;
    slicer_pkg::swing_dir_t dir;
    logic [slicer_pkg::ID_W-1:0] id;
    logic busy;

    modport sched(output load, x, y, color, dir, id, input busy);
    modport lane(input load, x, y, color, dir, id, output busy);
endinterface

// lane to arbiter, valid/ready
interface lane_event_if;
    logic valid;
    slicer_pkg::lane_event_t kind;
    logic [slicer_pkg::ID_W-1:0] id;
    logic ready;

    modport lane(output valid, kind, id, input ready);
    modport arb(input valid, kind, id, output ready);
endinterface

`default_nettype wire

//--- rtl/saber_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module saber_tracker (
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic saber_valid,
    input wire logic [slicer_pkg::COORD_W-1:0] left_x,
    input wire logic [slicer_pkg::COORD_W-1:0] left_y,
    input wire logic [slicer_pkg::COORD_W-1:0] right_x,
    input wire logic [slicer_pkg::COORD_W-1:0] right_y,
    saber_if.tracker sab
);

    // low until the first sample is stored
    logic have_sample;

    // swing from old to new point, x wins ties
    function automatic slicer_pkg::swing_dir_t classify(
        input logic [slicer_pkg::COORD_W-1:0] old_x,
        input logic [slicer_pkg::COORD_W-1:0] old_y,
        input logic [slicer_pkg::COORD_W-1:0] new_x,
        input logic [slicer_pkg::COORD_W-1:0] new_y
    );
        logic [slicer_pkg::COORD_W-1:0] dx;
        logic [slicer_pkg::COORD_W-1:0] dy;
        dx = (new_x >= old_x) ? new_x - old_x : old_x - new_x;
        dy = (new_y >= old_y) ? new_y - old_y : old_y - new_y;
        // too small on both axes
        if (dx < slicer_pkg::MIN_SWING && dy < slicer_pkg::MIN_SWING) begin
            return slicer_pkg::DIR_NONE;
        end
        if (dx >= dy) begin
            return (new_x > old_x) ? slicer_pkg::DIR_RIGHT : slicer_pkg::DIR_LEFT;
        end
        // screen y grows downward
        return (new_y > old_y) ? slicer_pkg::DIR_DOWN : slicer_pkg::DIR_UP;
    endfunction

    // sample registers, old value is the previous point
    always_ff @(posedge clk_in) begin
        if (saber_valid) begin
            sab.left_x <= left_x;
            sab.left_y <= left_y;
            sab.right_x <= right_x;
            sab.right_y <= right_y;
        end
    end

    // direction lands together with the new sample, held until the next one
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            have_sample <= 1'b0;
            sab.left_dir <= slicer_pkg::DIR_NONE;
            sab.right_dir <= slicer_pkg::DIR_NONE;
        end else if (saber_valid) begin
            have_sample <= 1'b1;
            sab.left_dir <= have_sample ?
                classify(sab.left_x, sab.left_y, left_x, left_y) : slicer_pkg::DIR_NONE;
            sab.right_dir <= have_sample ?
                classify(sab.right_x, sab.right_y, right_x, right_y) : slicer_pkg::DIR_NONE;
        end
    end

endmodule

`default_nettype wire

//--- rtl/block_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module block_scheduler (
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic playing,
    input wire logic chart_valid,
    input wire logic [slicer_pkg::COORD_W-1:0] chart_x,
    input wire logic [slicer_pkg::COORD_W-1:0] chart_y,
    input wire slicer_pkg::block_color_t chart_color,
    input wire slicer_pkg::swing_dir_t chart_dir,
    output logic chart_ready,
    lane_load_if.sched lanes [slicer_pkg::NUM_LANES]
);

    slicer_pkg::lane_vec_t busy;
    slicer_pkg::lane_vec_t load_q;
    slicer_pkg::lane_vec_t free;
    slicer_pkg::lane_vec_t pick;
    logic accept;

    // entry held for the load cycle, broadcast to all lanes
    logic [slicer_pkg::COORD_W-1:0] x_q;
    logic [slicer_pkg::COORD_W-1:0] y_q;
    slicer_pkg::block_color_t color_q;
    slicer_pkg::swing_dir_t dir_q;
    logic [slicer_pkg::ID_W-1:0] id_q;
    logic [slicer_pkg::ID_W-1:0] next_id;

    // a lane being loaded is not busy yet, so mask it too
    assign free = ~busy & ~load_q;
    // lowest set bit
    assign pick = free & (~free + slicer_pkg::lane_vec_t'(1));
    assign chart_ready = playing && (free != '0);
    assign accept = chart_valid && chart_ready;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            load_q <= '0;
            next_id <= '0;
        end else begin
            load_q <= accept ? pick : '0;
            // numbering restarts with every new game
            if (!playing) begin
                next_id <= '0;
            end else if (accept) begin
                next_id <= next_id + slicer_pkg::ID_W'(1);
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            x_q <= chart_x;
            y_q <= chart_y;
            color_q <= chart_color;
            dir_q <= chart_dir;
            id_q <= next_id;
        end
    end

    //////////////////////////////
    // per lane hookup
    for (genvar g = 0; g < slicer_pkg::NUM_LANES; g++) begin : g_lane
        assign busy[g] = lanes[g].busy;
        assign lanes[g].load = load_q[g];
        assign lanes[g].x = x_q;
        assign lanes[g].y = y_q;
        assign lanes[g].color = color_q;
        assign lanes[g].dir = dir_q;
        assign lanes[g].id = id_q;
    end

endmodule

`default_nettype wire

//--- rtl/block_lane.sv
`timescale 1ns/1ns
`default_nettype none

module block_lane (
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic frame_tick,
    lane_load_if.lane ld,
    saber_if.lane sab,
    lane_event_if.lane ev
);

    logic busy;

    // block payload
    logic [slicer_pkg::Z_W-1:0] z;
    logic [slicer_pkg::COORD_W-1:0] bx;
    logic [slicer_pkg::COORD_W-1:0] by;
    slicer_pkg::block_color_t color;
    slicer_pkg::swing_dir_t dir;
    logic [slicer_pkg::ID_W-1:0] id;

    // saber that matches the block color
    logic [slicer_pkg::COORD_W-1:0] sx;
    logic [slicer_pkg::COORD_W-1:0] sy;
    slicer_pkg::swing_dir_t sdir;
    logic [slicer_pkg::COORD_W-1:0] dist_x;
    logic [slicer_pkg::COORD_W-1:0] dist_y;
    logic near;
    logic dir_ok;
    logic active;
    logic hit;
    logic miss;

    always_comb begin
        if (color == slicer_pkg::COLOR_LEFT) begin
            sx = sab.left_x;
            sy = sab.left_y;
            sdir = sab.left_dir;
        end else begin
            sx = sab.right_x;
            sy = sab.right_y;
            sdir = sab.right_dir;
        end
    end

    assign dist_x = (sx >= bx) ? sx - bx : bx - sx;
    assign dist_y = (sy >= by) ? sy - by : by - sy;
    assign near = (dist_x <= slicer_pkg::HIT_RADIUS) && (dist_y <= slicer_pkg::HIT_RADIUS);
    // DIR_ANY wants some real swing
    assign dir_ok = (sdir == dir) ||
                    (dir == slicer_pkg::DIR_ANY && sdir != slicer_pkg::DIR_NONE);

    // holding a block and no event waiting
    assign active = busy && !ev.valid;
    assign hit = active && (z <= slicer_pkg::HIT_ZONE_Z) && near && dir_ok;
    assign miss = active && (z == '0) && !hit;

    assign ld.busy = busy;
    assign ev.id = id;

    //////////////////////////////
    // control
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            ev.valid <= 1'b0;
        end else if (ld.load) begin
            busy <= 1'b1;
        end else if (ev.valid && ev.ready) begin
            // handshake done, lane free next cycle
            busy <= 1'b0;
            ev.valid <= 1'b0;
        end else if (hit || miss) begin
            ev.valid <= 1'b1;
        end
    end

    //////////////////////////////
    // depth and payload
    always_ff @(posedge clk_in) begin
        if (ld.load) begin
            z <= slicer_pkg::SPAWN_Z;
            bx <= ld.x;
            by <= ld.y;
            color <= ld.color;
            dir <= ld.dir;
            id <= ld.id;
        end else if (active && frame_tick && !hit && z != '0) begin
            // step toward the player, floor at 0
            z <= (z > slicer_pkg::BLOCK_SPEED) ? z - slicer_pkg::BLOCK_SPEED : '0;
        end
        if (hit || miss) begin
            ev.kind <= hit ? slicer_pkg::EV_SLICE : slicer_pkg::EV_MISS;
        end
    end

endmodule

`default_nettype wire

//--- rtl/event_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module event_arbiter (
    input wire logic clk_in,
    input wire logic rst_in,
    lane_event_if.arb lanes [slicer_pkg::NUM_LANES],
    output logic result_valid,
    output slicer_pkg::lane_event_t result_kind,
    output logic [slicer_pkg::ID_W-1:0] result_id
);

    slicer_pkg::lane_vec_t valid;
    slicer_pkg::lane_vec_t grant;
    slicer_pkg::lane_event_t kind [slicer_pkg::NUM_LANES];
    logic [slicer_pkg::ID_W-1:0] id [slicer_pkg::NUM_LANES];
    slicer_pkg::lane_event_t sel_kind;
    logic [slicer_pkg::ID_W-1:0] sel_id;

    for (genvar g = 0; g < slicer_pkg::NUM_LANES; g++) begin : g_lane
        assign valid[g] = lanes[g].valid;
        assign kind[g] = lanes[g].kind;
        assign id[g] = lanes[g].id;
        assign lanes[g].ready = grant[g];
    end

    // fixed priority, lane 0 first, one grant at most
    assign grant = valid & (~valid + slicer_pkg::lane_vec_t'(1));

    // one hot mux of the granted event
    always_comb begin
        sel_kind = slicer_pkg::EV_MISS;
        sel_id = '0;
        for (int unsigned i = 0; i < slicer_pkg::NUM_LANES; i++) begin
            if (grant[i]) begin
                sel_kind = kind[i];
                sel_id = id[i];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= |grant;
        end
    end

    always_ff @(posedge clk_in) begin
        if (|grant) begin
            result_kind <= sel_kind;
            result_id <= sel_id;
        end
    end

endmodule

`default_nettype wire

//--- rtl/game_state.sv
`timescale 1ns/1ns
`default_nettype none

module game_state (
    input wire logic clk_in,
    input wire logic rst_in,
    input wire logic start,
    input wire logic result_valid,
    input wire slicer_pkg::lane_event_t result_kind,
    output logic playing,
    output logic game_over,
    output logic [slicer_pkg::SCORE_W-1:0] score,
    output logic [slicer_pkg::HEALTH_W-1:0] health,
    output logic [slicer_pkg::COMBO_W-1:0] combo
);

    slicer_pkg::play_state_t state;

    // slice value grows with the current combo
    logic [slicer_pkg::SCORE_W-1:0] points;

    assign points = slicer_pkg::SLICE_POINTS *
                    (slicer_pkg::SCORE_W'(combo) + slicer_pkg::SCORE_W'(1));

    assign playing = (state == slicer_pkg::ST_PLAYING);
    assign game_over = (state == slicer_pkg::ST_OVER);

    //////////////////////////////
    // play FSM
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= slicer_pkg::ST_IDLE;
            score <= '0;
            health <= slicer_pkg::MAX_HEALTH;
            combo <= '0;
        end else begin
            case (state)
                slicer_pkg::ST_IDLE, slicer_pkg::ST_OVER: begin
                    // fresh game, events here are ignored
                    if (start) begin
                        state <= slicer_pkg::ST_PLAYING;
                        score <= '0;
                        health <= slicer_pkg::MAX_HEALTH;
                        combo <= '0;
                    end
                end
                slicer_pkg::ST_PLAYING: begin
                    if (result_valid) begin
                        if (result_kind == slicer_pkg::EV_SLICE) begin
                            // score wraps
                            score <= score + points;
                            if (combo != slicer_pkg::MAX_COMBO) begin
                                combo <= combo + slicer_pkg::COMBO_W'(1);
                            end
                        end else begin
                            combo <= '0;
                            health <= health - slicer_pkg::HEALTH_W'(1);
                            // last life gone
                            if (health == slicer_pkg::HEALTH_W'(1)) begin
                                state <= slicer_pkg::ST_OVER;
                            end
                        end
                    end
                end
                default: begin
                    state <= slicer_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/beat_slicer_top.sv
`timescale 1ns/1ns
`default_nettype none

module beat_slicer_top (
    input wire logic clk_in,
    input wire logic rst_in,
    // chart entries
    input wire logic chart_valid,
    output logic chart_ready,
    input wire logic [slicer_pkg::COORD_W-1:0] chart_x,
    input wire logic [slicer_pkg::COORD_W-1:0] chart_y,
    input wire slicer_pkg::block_color_t chart_color,
    input wire slicer_pkg::swing_dir_t chart_dir,
    // hand samples, one point per saber
    input wire logic saber_valid,
    input wire logic [slicer_pkg::COORD_W-1:0] left_x,
    input wire logic [slicer_pkg::COORD_W-1:0] left_y,
    input wire logic [slicer_pkg::COORD_W-1:0] right_x,
    input wire logic [slicer_pkg::COORD_W-1:0] right_y,
    input wire logic start,
    input wire logic frame_tick,
    // results and game status
    output logic result_valid,
    output slicer_pkg::lane_event_t result_kind,
    output logic [slicer_pkg::ID_W-1:0] result_id,
    output logic [slicer_pkg::SCORE_W-1:0] score,
    output logic [slicer_pkg::HEALTH_W-1:0] health,
    output logic [slicer_pkg::COMBO_W-1:0] combo,
    output logic game_over
);

    logic playing;

    saber_if sab();
    lane_load_if lane_ld [slicer_pkg::NUM_LANES] ();
    lane_event_if lane_ev [slicer_pkg::NUM_LANES] ();

    //////////////////////////////
    // front end
    saber_tracker saber_tracker_inst (
        .clk_in(clk_in), .rst_in(rst_in), .saber_valid(saber_valid),
        .left_x(left_x), .left_y(left_y), .right_x(right_x), .right_y(right_y),
        .sab(sab)
    );

    block_scheduler block_scheduler_inst (
        .clk_in(clk_in), .rst_in(rst_in), .playing(playing),
        .chart_valid(chart_valid), .chart_x(chart_x), .chart_y(chart_y),
        .chart_color(chart_color), .chart_dir(chart_dir),
        .chart_ready(chart_ready), .lanes(lane_ld)
    );

    // lane trackers
    for (genvar g = 0; g < slicer_pkg::NUM_LANES; g++) begin : g_lane
        block_lane block_lane_inst (
            .clk_in(clk_in), .rst_in(rst_in), .frame_tick(frame_tick),
            .ld(lane_ld[g]), .sab(sab), .ev(lane_ev[g])
        );
    end

    //////////////////////////////
    // back end
    event_arbiter event_arbiter_inst (
        .clk_in(clk_in), .rst_in(rst_in), .lanes(lane_ev),
        .result_valid(result_valid), .result_kind(result_kind), .result_id(result_id)
    );

    game_state game_state_inst (
        .clk_in(clk_in), .rst_in(rst_in), .start(start),
        .result_valid(result_valid), .result_kind(result_kind),
        .playing(playing), .game_over(game_over),
        .score(score), .health(health), .combo(combo)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_in,
    output logic rst_in
);

    localparam int HALF_PERIOD = 2;
    localparam int RESET_CYCLES = 5;

    // 4 ns period
    initial begin
        clk_in = 1'b0;
        forever #HALF_PERIOD clk_in = ~clk_in;
    end

    // reset held for a few cycles, released on a falling edge
    initial begin
        rst_in = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/beat_slicer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module beat_slicer_tb;

    localparam int NUM_ROWS = 11;
    localparam int TICK_GAP = 4;
    localparam int CLK_PERIOD = 4;
    localparam int PARK = 4000;
    // x of the last block in the full lane test
    localparam int LAST_X = 300 + 100 * (slicer_pkg::NUM_LANES - 1);
    // every row plus the two extra tests, at most 20 ticks each
    localparam int LIMIT_NS = (NUM_ROWS + 2) * 20 * TICK_GAP * CLK_PERIOD + 2000;

    logic clk_in;
    logic rst_in;
    logic chart_valid;
    logic chart_ready;
    logic [slicer_pkg::COORD_W-1:0] chart_x;
    logic [slicer_pkg::COORD_W-1:0] chart_y;
    slicer_pkg::block_color_t chart_color;
    slicer_pkg::swing_dir_t chart_dir;
    logic saber_valid;
    logic [slicer_pkg::COORD_W-1:0] left_x;
    logic [slicer_pkg::COORD_W-1:0] left_y;
    logic [slicer_pkg::COORD_W-1:0] right_x;
    logic [slicer_pkg::COORD_W-1:0] right_y;
    logic start;
    logic frame_tick;
    logic result_valid;
    slicer_pkg::lane_event_t result_kind;
    logic [slicer_pkg::ID_W-1:0] result_id;
    logic [slicer_pkg::SCORE_W-1:0] score;
    logic [slicer_pkg::HEALTH_W-1:0] health;
    logic [slicer_pkg::COMBO_W-1:0] combo;
    logic game_over;

    // row table, hand 0 left, 1 right, 2 no swing
    string row_name [NUM_ROWS];
    int row_restart [NUM_ROWS];
    slicer_pkg::block_color_t row_color [NUM_ROWS];
    slicer_pkg::swing_dir_t row_dir [NUM_ROWS];
    int row_hand [NUM_ROWS];
    // swing start and end as offsets from the block
    int row_sx0 [NUM_ROWS];
    int row_sy0 [NUM_ROWS];
    int row_sx1 [NUM_ROWS];
    int row_sy1 [NUM_ROWS];
    slicer_pkg::lane_event_t row_kind [NUM_ROWS];
    int row_score [NUM_ROWS];
    int row_health [NUM_ROWS];
    int row_combo [NUM_ROWS];

    int kind_q [$];
    int id_q [$];
    int errors = 0;
    int tests = 0;
    int failed = 0;
    int next_id = 0;

    tb_clock_gen tb_clock_gen_inst (.clk_in(clk_in), .rst_in(rst_in));

    beat_slicer_top beat_slicer_top_inst (
        .clk_in(clk_in), .rst_in(rst_in),
        .chart_valid(chart_valid), .chart_ready(chart_ready),
        .chart_x(chart_x), .chart_y(chart_y),
        .chart_color(chart_color), .chart_dir(chart_dir),
        .saber_valid(saber_valid), .left_x(left_x), .left_y(left_y),
        .right_x(right_x), .right_y(right_y),
        .start(start), .frame_tick(frame_tick),
        .result_valid(result_valid), .result_kind(result_kind), .result_id(result_id),
        .score(score), .health(health), .combo(combo), .game_over(game_over)
    );

    // collect every result pulse
    always @(negedge clk_in) begin
        if (!rst_in && result_valid) begin
            kind_q.push_back(int'(result_kind));
            id_q.push_back(int'(result_id));
        end
    end

    initial begin
        #LIMIT_NS;
        $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////
    // helpers

    task automatic check(input string test, input string what, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            errors++;
            $display("Error %s %s: expected %0d, actual %0d", test, what, exp_v, act_v);
        end
    endtask

    task automatic set_row(input int i, input string name, input int restart,
                           input slicer_pkg::block_color_t color,
                           input slicer_pkg::swing_dir_t dir, input int hand,
                           input int sx0, input int sy0, input int sx1, input int sy1,
                           input slicer_pkg::lane_event_t kind,
                           input int exp_score, input int exp_health, input int exp_combo);
        row_name[i] = name;
        row_restart[i] = restart;
        row_color[i] = color;
        row_dir[i] = dir;
        row_hand[i] = hand;
        row_sx0[i] = sx0;
        row_sy0[i] = sy0;
        row_sx1[i] = sx1;
        row_sy1[i] = sy1;
        row_kind[i] = kind;
        row_score[i] = exp_score;
        row_health[i] = exp_health;
        row_combo[i] = exp_combo;
    endtask

    task automatic pulse_start();
        @(negedge clk_in);
        start = 1'b1;
        @(negedge clk_in);
        start = 1'b0;
        next_id = 0;
    endtask

    task automatic send_sample(input int lx, input int ly, input int rx, input int ry);
        @(negedge clk_in);
        saber_valid = 1'b1;
        left_x = slicer_pkg::COORD_W'(lx);
        left_y = slicer_pkg::COORD_W'(ly);
        right_x = slicer_pkg::COORD_W'(rx);
        right_y = slicer_pkg::COORD_W'(ry);
        @(negedge clk_in);
        saber_valid = 1'b0;
    endtask

    // two equal far samples leave both swings at none
    task automatic park_sabers();
        send_sample(PARK, PARK, PARK, PARK);
        send_sample(PARK, PARK, PARK, PARK);
    endtask

    task automatic load_block(input int bx, input int by,
                              input slicer_pkg::block_color_t color,
                              input slicer_pkg::swing_dir_t dir);
        @(negedge clk_in);
        chart_valid = 1'b1;
        chart_x = slicer_pkg::COORD_W'(bx);
        chart_y = slicer_pkg::COORD_W'(by);
        chart_color = color;
        chart_dir = dir;
        while (!chart_ready) @(negedge clk_in);
        @(negedge clk_in);
        chart_valid = 1'b0;
        next_id++;
    endtask

    task automatic report(input string test, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", test);
        end else begin
            failed++;
            $display("test %s: failed", test);
        end
    endtask

    //////////////////////////////
    // one table row, one block

    task automatic run_row(input int i);
        int errs_before;
        int bx;
        int by;
        int exp_id;
        errs_before = errors;
        if (row_restart[i] != 0) pulse_start();
        park_sabers();
        kind_q.delete();
        id_q.delete();
        bx = 200 + int'($urandom % 1601);
        by = 200 + int'($urandom % 701);
        exp_id = next_id % 256;
        load_block(bx, by, row_color[i], row_dir[i]);
        // tick 12 leaves the block at the hit zone edge, swing right after it
        for (int c = 1; c <= 20 * TICK_GAP && kind_q.size() == 0; c++) begin
            @(negedge clk_in);
            frame_tick = (c % TICK_GAP == 0);
            if (c == 12 * TICK_GAP + 1 && row_hand[i] == 0) begin
                send_sample(bx + row_sx0[i], by + row_sy0[i], PARK, PARK);
                send_sample(bx + row_sx1[i], by + row_sy1[i], PARK, PARK);
            end else if (c == 12 * TICK_GAP + 1 && row_hand[i] == 1) begin
                send_sample(PARK, PARK, bx + row_sx0[i], by + row_sy0[i]);
                send_sample(PARK, PARK, bx + row_sx1[i], by + row_sy1[i]);
            end
        end
        frame_tick = 1'b0;
        if (kind_q.size() == 0) begin
            errors++;
            $display("%s: the block never produced a result", row_name[i]);
        end else begin
            check(row_name[i], "result_kind", int'(row_kind[i]), kind_q[0]);
            check(row_name[i], "result_id", exp_id, id_q[0]);
        end
        // game state settles the cycle after the result
        repeat (2) @(negedge clk_in);
        check(row_name[i], "score", row_score[i], int'(score));
        check(row_name[i], "health", row_health[i], int'(health));
        check(row_name[i], "combo", row_combo[i], int'(combo));
        check(row_name[i], "game_over", int'(row_health[i] == 0), int'(game_over));
        report(row_name[i], errs_before);
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        int errs_before;
        int first_id;
        chart_valid = 1'b0;
        chart_x = '0;
        chart_y = '0;
        chart_color = slicer_pkg::COLOR_LEFT;
        chart_dir = slicer_pkg::DIR_NONE;
        saber_valid = 1'b0;
        left_x = '0;
        left_y = '0;
        right_x = '0;
        right_y = '0;
        start = 1'b0;
        frame_tick = 1'b0;
        void'($urandom(32'h0308_09de));

        // slices climb with combo, capped at 4, then four misses end the game
        set_row(0, "slice_right", 0, slicer_pkg::COLOR_LEFT, slicer_pkg::DIR_RIGHT, 0,
                -100, 0, 0, 0, slicer_pkg::EV_SLICE, 10, 4, 1);
        set_row(1, "slice_down", 0, slicer_pkg::COLOR_RIGHT, slicer_pkg::DIR_DOWN, 1,
                0, -100, 0, 0, slicer_pkg::EV_SLICE, 30, 4, 2);
        set_row(2, "slice_any", 0, slicer_pkg::COLOR_LEFT, slicer_pkg::DIR_ANY, 0,
                0, 100, 0, 0, slicer_pkg::EV_SLICE, 60, 4, 3);
        set_row(3, "slice_left", 0, slicer_pkg::COLOR_RIGHT, slicer_pkg::DIR_LEFT, 1,
                100, 0, 0, 0, slicer_pkg::EV_SLICE, 100, 4, 4);
        set_row(4, "slice_combo_cap", 0, slicer_pkg::COLOR_LEFT, slicer_pkg::DIR_UP, 0,
                0, 100, 0, 0, slicer_pkg::EV_SLICE, 150, 4, 4);
        set_row(5, "no_swing", 0, slicer_pkg::COLOR_LEFT, slicer_pkg::DIR_RIGHT, 2,
                0, 0, 0, 0, slicer_pkg::EV_MISS, 150, 3, 0);
        set_row(6, "wrong_hand", 0, slicer_pkg::COLOR_LEFT, slicer_pkg::DIR_RIGHT, 1,
                -100, 0, 0, 0, slicer_pkg::EV_MISS, 150, 2, 0);
        set_row(7, "wrong_dir", 0, slicer_pkg::COLOR_LEFT, slicer_pkg::DIR_DOWN, 0,
                -100, 0, 0, 0, slicer_pkg::EV_MISS, 150, 1, 0);
        set_row(8, "outside_radius", 0, slicer_pkg::COLOR_LEFT, slicer_pkg::DIR_RIGHT, 0,
                -200, 0, -100, 0, slicer_pkg::EV_MISS, 150, 0, 0);
        set_row(9, "small_swing", 1, slicer_pkg::COLOR_LEFT, slicer_pkg::DIR_RIGHT, 0,
                -10, 0, 0, 0, slicer_pkg::EV_MISS, 0, 3, 0);
        set_row(10, "slice_after_restart", 0, slicer_pkg::COLOR_RIGHT, slicer_pkg::DIR_ANY, 1,
                -100, 0, 0, 0, slicer_pkg::EV_SLICE, 10, 3, 1);

        wait (rst_in == 1'b0);
        errs_before = errors;
        repeat (5) @(negedge clk_in);
        check("reset_idle", "score", 0, int'(score));
        check("reset_idle", "health", int'(slicer_pkg::MAX_HEALTH), int'(health));
        check("reset_idle", "combo", 0, int'(combo));
        check("reset_idle", "chart_ready", 0, int'(chart_ready));
        check("reset_idle", "game_over", 0, int'(game_over));
        check("reset_idle", "result count", 0, kind_q.size());
        pulse_start();
        @(negedge clk_in);
        check("reset_idle", "chart_ready after start", 1, int'(chart_ready));
        report("reset_idle", errs_before);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        // fill every lane, all reach the player together and drain in order
        // right saber rests on the last block, flicks down as it lands
        errs_before = errors;
        kind_q.delete();
        id_q.delete();
        first_id = next_id;
        send_sample(PARK, PARK, LAST_X, 500);
        send_sample(PARK, PARK, LAST_X, 500);
        for (int n = 0; n < slicer_pkg::NUM_LANES - 1; n++) begin
            load_block(300 + 100 * n, 500, slicer_pkg::COLOR_LEFT, slicer_pkg::DIR_UP);
        end
        load_block(LAST_X, 500, slicer_pkg::COLOR_RIGHT, slicer_pkg::DIR_ANY);
        check("back_pressure", "chart_ready when full", 0, int'(chart_ready));
        right_y = slicer_pkg::COORD_W'(540);
        for (int c = 1; c <= 20 * TICK_GAP && kind_q.size() == 0; c++) begin
            @(negedge clk_in);
            frame_tick = (c % TICK_GAP == 0);
            // sample lands with the last tick
            saber_valid = (c == 16 * TICK_GAP);
        end
        frame_tick = 1'b0;
        saber_valid = 1'b0;
        check("back_pressure", "chart_ready after first result", 1, int'(chart_ready));
        for (int c = 0; c < 40 && kind_q.size() < slicer_pkg::NUM_LANES; c++) begin
            @(negedge clk_in);
        end
        if (kind_q.size() != slicer_pkg::NUM_LANES) begin
            errors++;
            $display("back_pressure: only %0d of the lanes reported", kind_q.size());
        end else begin
            for (int n = 0; n < slicer_pkg::NUM_LANES; n++) begin
                check("back_pressure", "result_kind",
                      (n == slicer_pkg::NUM_LANES - 1) ? int'(slicer_pkg::EV_SLICE)
                                                       : int'(slicer_pkg::EV_MISS),
                      kind_q[n]);
                check("back_pressure", "result_id", (first_id + n) % 256, id_q[n]);
            end
        end
        report("back_pressure", errs_before);

        // three misses ended the game, the rest and the late slice changed nothing
        errs_before = errors;
        repeat (2) @(negedge clk_in);
        check("game_over", "game_over", 1, int'(game_over));
        check("game_over", "chart_ready", 0, int'(chart_ready));
        check("game_over", "score", 10, int'(score));
        check("game_over", "health", 0, int'(health));
        check("game_over", "combo", 0, int'(combo));
        pulse_start();
        @(negedge clk_in);
        check("game_over", "score after start", 0, int'(score));
        check("game_over", "health after start", int'(slicer_pkg::MAX_HEALTH), int'(health));
        check("game_over", "combo after start", 0, int'(combo));
        check("game_over", "game_over after start", 0, int'(game_over));
        check("game_over", "chart_ready after start", 1, int'(chart_ready));
        report("game_over", errs_before);

        $display("tests %0d, failed %0d, mismatches %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- beat_slicer_top.f
rtl/slicer_pkg.sv
rtl/slicer_ifs.sv
rtl/saber_tracker.sv
rtl/block_scheduler.sv
rtl/block_lane.sv
rtl/event_arbiter.sv
rtl/game_state.sv
rtl/beat_slicer_top.sv
testbench/tb_clock_gen.sv
testbench/beat_slicer_tb.sv

//--- Makefile
# Verilator build and run for the beat slicer core

TOP      ?= beat_slicer_tb
RTL_TOP  ?= beat_slicer_top
FILELIST ?= beat_slicer_top.f
SEED     ?= 1
VFLAGS   ?= --timing -Wno-fatal
OBJ_DIR  ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	verilator --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
